// File: common/icache_pkg.sv
package icache_pkg;

  // ----------------------------------------
  // Cache geometry
  // ----------------------------------------

  // Fetch address width
  localparam int ADDR_BITS = 32;

  // One line is 16 bytes
  localparam int LINE_BITS = 128;

  // Tag from address bits 31..8
  localparam int TAG_BITS = 24;

  // Set index from address bits 7..4
  localparam int INDEX_BITS = 4;

  // 16 sets of 8 ways, 2 KB in total
  localparam int SETS = 16;
  localparam int WAYS = 8;

  // Width of a way number
  localparam int WAY_BITS = 3;

  // ----------------------------------------
  // State encodings
  // ----------------------------------------

  // Access stage
  typedef enum logic [1:0] {
    access_idle,
    access_lookup,
    access_refill_wait
  } access_state_e;

  // Refill engine
  typedef enum logic [1:0] {
    refill_idle,
    refill_request,
    refill_response
  } refill_state_e;

endpackage

// File: icache.f
common/icache_pkg.sv
icache/victim_select.sv
icache/cache_access.sv
icache/cache_refill.sv
rtl/icache_top.sv
test/tb_icache.sv

// File: icache/cache_access.sv
`timescale 1ns/1ns

module cache_access (
  input  logic                             clock,
  input  logic                             reset,
  // Fetch request
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [icache_pkg::ADDR_BITS-1:0] req_addr_i,
  // Line response
  output logic                             resp_valid_o,
  input  logic                             resp_ready_i,
  output logic [icache_pkg::ADDR_BITS-1:0] resp_addr_o,
  output logic [icache_pkg::LINE_BITS-1:0] resp_data_o,
  output logic                             resp_hit_o,
  // Drop the request in flight
  input  logic                             flush_i,
  // Miss to the refill engine
  output logic                              miss_o,
  output logic [icache_pkg::ADDR_BITS-1:0]  miss_addr_o,
  // Line write from the refill engine
  input  logic                              fill_en_i,
  input  logic [icache_pkg::INDEX_BITS-1:0] fill_index_i,
  input  logic [icache_pkg::WAY_BITS-1:0]   fill_way_i,
  input  logic [icache_pkg::TAG_BITS-1:0]   fill_tag_i,
  input  logic [icache_pkg::LINE_BITS-1:0]  fill_data_i
);

  // Per set valid bits, tags and lines
  logic [icache_pkg::WAYS-1:0]      valid_q [icache_pkg::SETS];
  logic [icache_pkg::TAG_BITS-1:0]  tag_q   [icache_pkg::SETS][icache_pkg::WAYS];
  logic [icache_pkg::LINE_BITS-1:0] data_q  [icache_pkg::SETS][icache_pkg::WAYS];

  icache_pkg::access_state_e state_q;
  icache_pkg::access_state_e state_d;

  // Request register and its fields
  logic [icache_pkg::ADDR_BITS-1:0]  addr_q;
  logic [icache_pkg::TAG_BITS-1:0]   req_tag;
  logic [icache_pkg::INDEX_BITS-1:0] req_index;
  // Set once this request took the refill path
  logic                              missed_q;

  // Tag compare results
  logic [icache_pkg::WAYS-1:0]       way_match;
  logic                              hit;
  logic [icache_pkg::WAY_BITS-1:0]   hit_way;

  // Response line kept while the consumer stalls
  logic                              hold_q;
  logic [icache_pkg::LINE_BITS-1:0]  hold_data_q;

  logic                              req_fire;
  logic                              resp_fire;

  assign req_tag   = addr_q[icache_pkg::ADDR_BITS-1 -: icache_pkg::TAG_BITS];
  assign req_index = addr_q[icache_pkg::ADDR_BITS-icache_pkg::TAG_BITS-1 -: icache_pkg::INDEX_BITS];

  assign req_fire  = req_valid_i && req_ready_o;
  assign resp_fire = resp_valid_o && resp_ready_i;

  // ----------------------------------------
  // Arrays
  // ----------------------------------------

  // Valid bits, cleared at reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (fill_en_i) begin
      valid_q[fill_index_i][fill_way_i] <= 1'b1;
    end
  end

  // Tag and line written together with the valid bit
  always_ff @(posedge clock) begin
    if (fill_en_i) begin
      tag_q[fill_index_i][fill_way_i]  <= fill_tag_i;
      data_q[fill_index_i][fill_way_i] <= fill_data_i;
    end
  end

  // ----------------------------------------
  // Hit detection
  // ----------------------------------------

  // Compare all eight ways of the indexed set
  always_comb begin
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      way_match[w] = valid_q[req_index][w] && (tag_q[req_index][w] == req_tag);
    end
  end

  // Priority encoder, lowest way wins
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        hit     = 1'b1;
        hit_way = w[icache_pkg::WAY_BITS-1:0];
      end
    end
  end

  // ----------------------------------------
  // Request register
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      addr_q   <= '0;
      missed_q <= 1'b0;
    end else if (req_fire) begin
      addr_q   <= req_addr_i;
      missed_q <= 1'b0;
    end else if (miss_o) begin
      missed_q <= 1'b1;
    end
  end

  // Freeze the line on the first stalled cycle
  always_ff @(posedge clock) begin
    if (reset || flush_i || resp_fire) begin
      hold_q <= 1'b0;
    end else if (resp_valid_o) begin
      hold_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (resp_valid_o && !hold_q) begin
      hold_data_q <= data_q[req_index][hit_way];
    end
  end

  // ----------------------------------------
  // Access FSM
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      state_q <= icache_pkg::access_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::access_idle: begin
        if (req_fire) begin
          state_d = icache_pkg::access_lookup;
        end
      end
      icache_pkg::access_lookup: begin
        if (resp_fire) begin
          state_d = icache_pkg::access_idle;
        end else if (miss_o) begin
          state_d = icache_pkg::access_refill_wait;
        end
      end
      icache_pkg::access_refill_wait: begin
        // Line lands at this edge, lookup then hits
        if (fill_en_i) begin
          state_d = icache_pkg::access_lookup;
        end
      end
      default: state_d = icache_pkg::access_idle;
    endcase
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  // One request in flight, new one only in idle
  assign req_ready_o = (state_q == icache_pkg::access_idle) && !flush_i;

  // Dropped request gives no response
  assign resp_valid_o = (state_q == icache_pkg::access_lookup) && (hit || hold_q) && !flush_i;
  assign resp_addr_o  = addr_q;
  assign resp_data_o  = hold_q ? hold_data_q : data_q[req_index][hit_way];
  assign resp_hit_o   = !missed_q;

  // A fill in this cycle may bring the line, so retry first
  assign miss_o      = (state_q == icache_pkg::access_lookup) && !hit && !hold_q && !fill_en_i;
  assign miss_addr_o = addr_q;

endmodule

// File: icache/cache_refill.sv
`timescale 1ns/1ns

module cache_refill (
  input  logic                              clock,
  input  logic                              reset,
  // Miss from the access stage
  input  logic                              miss_i,
  input  logic [icache_pkg::ADDR_BITS-1:0]  miss_addr_i,
  // Memory request, line aligned
  output logic                              mem_req_valid_o,
  input  logic                              mem_req_ready_i,
  output logic [icache_pkg::ADDR_BITS-1:0]  mem_req_addr_o,
  // Memory response, always accepted
  input  logic                              mem_resp_valid_i,
  input  logic [icache_pkg::LINE_BITS-1:0]  mem_resp_data_i,
  // Victim way lookup
  output logic [icache_pkg::INDEX_BITS-1:0] victim_index_o,
  input  logic [icache_pkg::WAY_BITS-1:0]   victim_way_i,
  output logic                              advance_o,
  // Line write into the arrays
  output logic                              fill_en_o,
  output logic [icache_pkg::INDEX_BITS-1:0] fill_index_o,
  output logic [icache_pkg::WAY_BITS-1:0]   fill_way_o,
  output logic [icache_pkg::TAG_BITS-1:0]   fill_tag_o,
  output logic [icache_pkg::LINE_BITS-1:0]  fill_data_o
);

  icache_pkg::refill_state_e state_q;
  icache_pkg::refill_state_e state_d;

  // Latched miss line, offset bits dropped
  logic [icache_pkg::TAG_BITS-1:0]   tag_q;
  logic [icache_pkg::INDEX_BITS-1:0] index_q;

  logic miss_take;
  logic req_fire;

  // Only one outstanding miss
  assign miss_take = (state_q == icache_pkg::refill_idle) && miss_i;
  assign req_fire  = mem_req_valid_o && mem_req_ready_i;

  // ----------------------------------------
  // Miss address
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (miss_take) begin
      tag_q   <= miss_addr_i[icache_pkg::ADDR_BITS-1 -: icache_pkg::TAG_BITS];
      index_q <= miss_addr_i[icache_pkg::ADDR_BITS-icache_pkg::TAG_BITS-1 -:
                             icache_pkg::INDEX_BITS];
    end
  end

  // ----------------------------------------
  // Refill FSM
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= icache_pkg::refill_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::refill_idle: begin
        if (miss_take) begin
          state_d = icache_pkg::refill_request;
        end
      end
      icache_pkg::refill_request: begin
        // Hold the request until memory takes it
        if (req_fire) begin
          state_d = icache_pkg::refill_response;
        end
      end
      icache_pkg::refill_response: begin
        // Line arrives and is written in the same cycle
        if (mem_resp_valid_i) begin
          state_d = icache_pkg::refill_idle;
        end
      end
      default: state_d = icache_pkg::refill_idle;
    endcase
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  // Line aligned memory address
  assign mem_req_valid_o = (state_q == icache_pkg::refill_request);
  assign mem_req_addr_o  = {tag_q, index_q,
                            {(icache_pkg::ADDR_BITS-icache_pkg::TAG_BITS-
                              icache_pkg::INDEX_BITS){1'b0}}};

  // Pointer of the missed set names the victim
  assign victim_index_o = index_q;

  // One cycle write, pointer moves on with it
  assign fill_en_o    = (state_q == icache_pkg::refill_response) && mem_resp_valid_i;
  assign advance_o    = fill_en_o;
  assign fill_index_o = index_q;
  assign fill_way_o   = victim_way_i;
  assign fill_tag_o   = tag_q;
  assign fill_data_o  = mem_resp_data_i;

endmodule

// File: icache/victim_select.sv
`timescale 1ns/1ns

module victim_select (
  input  logic                              clock,
  input  logic                              reset,
  // Set being refilled
  input  logic [icache_pkg::INDEX_BITS-1:0] index_i,
  // Step the pointer after a fill
  input  logic                              advance_i,
  // Way to replace next
  output logic [icache_pkg::WAY_BITS-1:0]   way_o
);

  // ----------------------------------------
  // Round-robin pointers
  // ----------------------------------------

  // One pointer per set
  logic [icache_pkg::WAY_BITS-1:0] ptr_q [icache_pkg::SETS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < icache_pkg::SETS; s++) begin
        ptr_q[s] <= '0;
      end
    end else if (advance_i) begin
      // Wrap after the last way
      if (ptr_q[index_i] == icache_pkg::WAY_BITS'(icache_pkg::WAYS - 1)) begin
        ptr_q[index_i] <= '0;
      end else begin
        ptr_q[index_i] <= ptr_q[index_i] + 1'b1;
      end
    end
  end

  // Current pointer of the named set
  assign way_o = ptr_q[index_i];

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/1ns

module icache_top (
  input  logic                             clock,
  input  logic                             reset,
  // Fetch side
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [icache_pkg::ADDR_BITS-1:0] req_addr_i,
  // Response side
  output logic                             resp_valid_o,
  input  logic                             resp_ready_i,
  output logic [icache_pkg::ADDR_BITS-1:0] resp_addr_o,
  output logic [icache_pkg::LINE_BITS-1:0] resp_data_o,
  output logic                             resp_hit_o,
  // Control
  input  logic                             flush_i,
  // Memory request
  output logic                             mem_req_valid_o,
  input  logic                             mem_req_ready_i,
  output logic [icache_pkg::ADDR_BITS-1:0] mem_req_addr_o,
  // Memory response
  input  logic                             mem_resp_valid_i,
  input  logic [icache_pkg::LINE_BITS-1:0] mem_resp_data_i
);

  // Miss path
  logic                              miss;
  logic [icache_pkg::ADDR_BITS-1:0]  miss_addr;

  // Fill path
  logic                              fill_en;
  logic [icache_pkg::INDEX_BITS-1:0] fill_index;
  logic [icache_pkg::WAY_BITS-1:0]   fill_way;
  logic [icache_pkg::TAG_BITS-1:0]   fill_tag;
  logic [icache_pkg::LINE_BITS-1:0]  fill_data;

  // Victim lookup
  logic [icache_pkg::INDEX_BITS-1:0] victim_index;
  logic [icache_pkg::WAY_BITS-1:0]   victim_way;
  logic                              advance;

  // ----------------------------------------
  // Access stage
  // ----------------------------------------

  cache_access cache_access_inst (
    .clock        (clock),
    .reset        (reset),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_addr_i   (req_addr_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o),
    .resp_hit_o   (resp_hit_o),
    .flush_i      (flush_i),
    .miss_o       (miss),
    .miss_addr_o  (miss_addr),
    .fill_en_i    (fill_en),
    .fill_index_i (fill_index),
    .fill_way_i   (fill_way),
    .fill_tag_i   (fill_tag),
    .fill_data_i  (fill_data)
  );

  // ----------------------------------------
  // Refill engine and victim pointers
  // ----------------------------------------

  cache_refill cache_refill_inst (
    .clock            (clock),
    .reset            (reset),
    .miss_i           (miss),
    .miss_addr_i      (miss_addr),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .victim_index_o   (victim_index),
    .victim_way_i     (victim_way),
    .advance_o        (advance),
    .fill_en_o        (fill_en),
    .fill_index_o     (fill_index),
    .fill_way_o       (fill_way),
    .fill_tag_o       (fill_tag),
    .fill_data_o      (fill_data)
  );

  victim_select victim_select_inst (
    .clock     (clock),
    .reset     (reset),
    .index_i   (victim_index),
    .advance_i (advance),
    .way_o     (victim_way)
  );

endmodule

// File: test/icache_input.txt
// address(hex) hit(0/1) stall(cycles held after the first valid one) flush(0/1)
// flush drops the request in the cycle after acceptance, stall is then unused
00001000 0 0 0
00001000 1 0 0
00001008 1 1 0
00001010 0 2 0
00001010 1 3 0
0000101c 1 0 0
00002000 0 1 0
00002004 1 0 0
00001000 1 4 0
00010020 0 0 0
00020020 0 1 0
00030020 0 0 0
00040020 0 2 0
00050020 0 0 0
00060020 0 3 0
00070020 0 0 0
00080020 0 1 0
00010020 1 0 0
00080020 1 0 0
00090020 0 0 0
00020020 1 2 0
00010020 0 0 0
00030020 1 0 0
00090020 1 1 0
00020020 0 0 0
00040020 1 0 0
00004030 0 0 1
00004030 1 0 0
00001010 1 0 1
00001010 1 2 0
00005040 0 5 0
00005040 1 5 0
00006050 0 0 1
00007050 0 3 0
00006050 1 0 0
00007050 1 0 0
00008060 0 2 0
0000806c 1 0 0
00009070 0 1 0
00009070 1 0 1
00009074 1 4 0
0000a080 0 0 0
0000a080 1 0 0
0000b0f0 0 3 0
0000b0f8 1 2 0
00001000 1 0 0

// File: test/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------

  logic                             clock = 1'b0;
  logic                             reset;
  logic                             req_valid_i;
  logic                             req_ready_o;
  logic [icache_pkg::ADDR_BITS-1:0] req_addr_i;
  logic                             resp_valid_o;
  logic                             resp_ready_i;
  logic [icache_pkg::ADDR_BITS-1:0] resp_addr_o;
  logic [icache_pkg::LINE_BITS-1:0] resp_data_o;
  logic                             resp_hit_o;
  logic                             flush_i;
  logic                             mem_req_valid_o;
  logic                             mem_req_ready_i;
  logic [icache_pkg::ADDR_BITS-1:0] mem_req_addr_o;
  logic                             mem_resp_valid_i;
  logic [icache_pkg::LINE_BITS-1:0] mem_resp_data_i;

  // Stimulus table with one slot per file line
  logic [31:0] addr_list [$];
  int          hit_list [$];
  int          stall_list [$];
  int          flush_list [$];

  // Error counts and run limit
  int          mismatch_count = 0;
  int          other_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          mem_req_count = 0;

  // Memory model state
  integer      seed = 32'hb0ba;
  logic [31:0] mem_line_addr;
  int          mem_delay;

  // Line address of the entry being run
  logic [31:0] entry_line_addr = '0;

  // Longest wait for one response including the miss path
  localparam int RESP_WAIT_LIMIT = 60;

  icache_top icache_top_inst (
    .clock            (clock),
    .reset            (reset),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_addr_i       (req_addr_i),
    .resp_valid_o     (resp_valid_o),
    .resp_ready_i     (resp_ready_i),
    .resp_addr_o      (resp_addr_o),
    .resp_data_o      (resp_data_o),
    .resp_hit_o       (resp_hit_o),
    .flush_i          (flush_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i)
  );

  // 40 ns period
  always #20 clock = ~clock;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Each of the four words is its address XOR a fixed pattern
  function automatic logic [127:0] line_for(input logic [31:0] line_addr);
    logic [127:0] line;
    for (int w = 0; w < 4; w++) begin
      line[32*w +: 32] = (line_addr + 4 * w) ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  task automatic expect_value(input string what, input logic [127:0] got,
                              input logic [127:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      mismatch_count++;
    end
  endtask

  // Valid response held with the right line
  task automatic check_response(input logic [31:0] addr, input logic [127:0] exp_line,
                                input int exp_hit);
    assert (resp_valid_o) else begin
      $display("resp_valid_o dropped before the transfer for address %h", addr);
      other_count++;
    end
    expect_value("resp_addr_o", resp_addr_o, addr);
    expect_value("resp_data_o", resp_data_o, exp_line);
    expect_value("resp_hit_o", resp_hit_o, exp_hit[0]);
    assert (!req_ready_o) else begin
      $display("req_ready_o high while a response for %h is pending", addr);
      other_count++;
    end
  endtask

  // One fetch from the table
  task automatic run_entry(input int i);
    logic [31:0]  addr;
    logic [127:0] exp_line;
    int           waited;
    addr            = addr_list[i];
    entry_line_addr = {addr[31:4], 4'h0};
    exp_line        = line_for(entry_line_addr);
    @(posedge clock);
    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    @(negedge clock);
    while (!req_ready_o) begin
      @(negedge clock);
    end
    // Acceptance edge
    @(posedge clock);
    req_valid_i <= 1'b0;
    if (flush_list[i] != 0) begin
      flush_i <= 1'b1;
      @(negedge clock);
      assert (!resp_valid_o) else begin
        $display("Response appeared for the flushed request to %h", addr);
        other_count++;
      end
      @(posedge clock);
      flush_i <= 1'b0;
      @(negedge clock);
      assert (!resp_valid_o) else begin
        $display("Response appeared after the flush of %h", addr);
        other_count++;
      end
      // Dropped miss still refills and must land first
      expect_value("refill after flush", mem_req_valid_o, hit_list[i] == 0);
      if (mem_req_valid_o) begin
        while (!mem_resp_valid_i) begin
          @(negedge clock);
        end
      end
    end else begin
      // Stall 0 means ready is already up when valid rises
      resp_ready_i <= (stall_list[i] == 0);
      waited = 0;
      @(negedge clock);
      while (!resp_valid_o && waited < RESP_WAIT_LIMIT) begin
        assert (!req_ready_o) else begin
          $display("req_ready_o high while %h is in flight", addr);
          other_count++;
        end
        waited++;
        @(negedge clock);
      end
      if (!resp_valid_o) begin
        $display("No response for the request to %h", addr);
        other_count++;
      end else begin
        // Hit answers in the cycle after acceptance
        if (hit_list[i] != 0) begin
          expect_value("hit latency in cycles", waited, 0);
        end else begin
          assert (waited > 0) else begin
            $display("Mismatch at %0t: miss for %h answered at once", $time, addr);
            mismatch_count++;
          end
        end
        check_response(addr, exp_line, hit_list[i]);
        if (stall_list[i] > 0) begin
          repeat (stall_list[i] - 1) begin
            @(posedge clock);
            @(negedge clock);
            check_response(addr, exp_line, hit_list[i]);
          end
          @(posedge clock);
          resp_ready_i <= 1'b1;
          @(negedge clock);
          check_response(addr, exp_line, hit_list[i]);
        end
        // Transfer at this edge
        @(posedge clock);
        resp_ready_i <= 1'b0;
      end
    end
  endtask

  // ----------------------------------------
  // Memory model and monitors
  // ----------------------------------------

  // Random delay on both the request and the response
  initial begin
    mem_req_ready_i  = 1'b0;
    mem_resp_valid_i = 1'b0;
    mem_resp_data_i  = '0;
    forever begin
      @(negedge clock);
      if (!reset && mem_req_valid_o) begin
        mem_line_addr = mem_req_addr_o;
        mem_delay = $random(seed) & 7;
        repeat (mem_delay) @(posedge clock);
        @(posedge clock);
        mem_req_ready_i <= 1'b1;
        @(posedge clock);
        mem_req_ready_i <= 1'b0;
        mem_delay = $random(seed) & 7;
        repeat (mem_delay) @(posedge clock);
        mem_resp_valid_i <= 1'b1;
        mem_resp_data_i  <= line_for(mem_line_addr);
        @(posedge clock);
        mem_resp_valid_i <= 1'b0;
      end
    end
  end

  // Count memory request transfers
  always @(negedge clock) begin
    if (!reset && mem_req_valid_o && mem_req_ready_i) begin
      mem_req_count++;
      expect_value("mem_req_addr_o", mem_req_addr_o, entry_line_addr);
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    int                fd;
    int                expected_misses;
    logic [8*128-1:0]  line_buf;
    logic [31:0]       f_addr;
    int                f_hit;
    int                f_stall;
    int                f_flush;
    reset        = 1'b1;
    req_valid_i  = 1'b0;
    req_addr_i   = '0;
    resp_ready_i = 1'b0;
    flush_i      = 1'b0;
    expected_misses = 0;
    fd = $fopen("test/icache_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/icache_input.txt");
      other_count++;
    end else begin
      // Comment lines fail the scan and drop out
      while ($fgets(line_buf, fd) != 0) begin
        if ($sscanf(line_buf, "%h %d %d %d", f_addr, f_hit, f_stall, f_flush) == 4) begin
          addr_list.push_back(f_addr);
          hit_list.push_back(f_hit);
          stall_list.push_back(f_stall);
          flush_list.push_back(f_flush);
          if (f_hit == 0) begin
            expected_misses++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = addr_list.size() * 40 + 200;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    // Idle outputs after reset
    expect_value("req_ready_o after reset", req_ready_o, 1'b1);
    expect_value("resp_valid_o after reset", resp_valid_o, 1'b0);
    expect_value("mem_req_valid_o after reset", mem_req_valid_o, 1'b0);
    for (int i = 0; i < addr_list.size(); i++) begin
      run_entry(i);
    end
    @(posedge clock);
    // One memory transfer per miss in the table
    expect_value("memory request count", mem_req_count, expected_misses);
    $display("Summary: %0d mismatches, %0d other errors over %0d entries",
             mismatch_count, other_count, addr_list.size());
    if (mismatch_count == 0 && other_count == 0 && addr_list.size() > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
